/* hw/buf_pkg.sv */
`default_nettype none

package buf_pkg;

    // ******************************************************************
    // Buffer geometry
    // ******************************************************************

    localparam int WORD_BITS = 128;
    localparam int DEPTH = 512;
    localparam int ADDR_BITS = 9;              // Word address into the macro

    localparam int LANE_BITS = 32;             // One APB data beat
    localparam int LANES = 4;
    localparam int LANE_SEL_BITS = 2;

    // ******************************************************************
    // Types
    // ******************************************************************

    // Lane 0 sits in the low bits of the word
    typedef logic [LANES-1:0][LANE_BITS-1:0] word_t;

    typedef struct packed {
        logic                 read_en;
        logic                 write_en;
        logic [ADDR_BITS-1:0] addr;
        logic [WORD_BITS-1:0] data;           // Write data that reads ignore
    } ram_req_t;

endpackage

`default_nettype wire

/* hw/apb_pkg.sv */
`default_nettype none

package apb_pkg;

    // ******************************************************************
    // APB port widths and address window
    // ******************************************************************

    localparam int APB_ADDR_BITS = 16;
    localparam int APB_DATA_BITS = 32;

    localparam int WINDOW_BYTES = 8192;        // 512 words of 16 bytes

    // ******************************************************************
    // Requester and completer sides of the bus
    // ******************************************************************

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [APB_ADDR_BITS-1:0] paddr;      // Byte address
        logic [APB_DATA_BITS-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                     pready;
        logic [APB_DATA_BITS-1:0] prdata;
        logic                     pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* hw/delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter int NUM_STAGES = 1,
    parameter int DATA_WIDTH = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [DATA_WIDTH-1:0] din,
    output logic [DATA_WIDTH-1:0] dout
);

    logic [DATA_WIDTH-1:0] stage_q [NUM_STAGES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            for (int i = 1; i < NUM_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];   // Shift one stage per clock
            end
        end
    end

    assign dout = stage_q[NUM_STAGES-1];

endmodule

`default_nettype wire

/* hw/sram_sp_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_sp_model (
    input  logic                          clk,
    input  logic [buf_pkg::ADDR_BITS-1:0] a,
    input  buf_pkg::word_t                di,
    output buf_pkg::word_t                do_word,
    input  logic                          web,
    input  logic                          csb
);

    // ******************************************************************
    // Storage array and output register
    // ******************************************************************

    buf_pkg::word_t mem [buf_pkg::DEPTH];

    always_ff @(posedge clk) begin
        if (!csb) begin
            if (!web) begin
                mem[a] <= di;
            end else begin
                do_word <= mem[a];              // Output holds until the next read
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sram_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_wrapper (
    input  logic              clk,
    input  logic              reset,
    input  buf_pkg::ram_req_t req,
    output buf_pkg::word_t    rdata
);

    // ******************************************************************
    // Macro pins
    // ******************************************************************

    logic [buf_pkg::ADDR_BITS-1:0] a;
    buf_pkg::word_t                di;
    buf_pkg::word_t                do_word;
    logic                          web;
    logic                          csb;

    logic           read_en_d;
    buf_pkg::word_t hold_q;

    assign a = req.addr;                        // One address field serves both strobes
    assign di = req.data;
    assign web = ~req.write_en;
    assign csb = ~(req.read_en | req.write_en); // Select the macro for either strobe

    sram_sp_model sram_inst (
        .clk     (clk),
        .a       (a),
        .di      (di),
        .do_word (do_word),
        .web     (web),
        .csb     (csb)
    );

    // ******************************************************************
    // Read return path
    // ******************************************************************

    delay_line #(
        .NUM_STAGES (1),
        .DATA_WIDTH (1)
    ) read_en_delay (
        .clk   (clk),
        .reset (reset),
        .din   (req.read_en),
        .dout  (read_en_d)
    );

    // The macro output is live for one cycle and the copy is shown after it
    always_ff @(posedge clk) begin
        if (read_en_d) begin
            hold_q <= do_word;
        end
    end

    assign rdata = read_en_d ? do_word : hold_q;

endmodule

`default_nettype wire

/* hw/apb_buffer_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_buffer_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp,
    output buf_pkg::ram_req_t ram_req,
    input  buf_pkg::word_t    ram_rdata
);

    typedef enum logic {
        st_idle,
        st_read_wait
    } state_t;

    state_t state_q;
    state_t state_d;

    logic                              access;
    logic                              in_window;
    logic [buf_pkg::LANE_SEL_BITS-1:0] lane;
    logic [buf_pkg::ADDR_BITS-1:0]     word_addr;
    logic                              wr_hit;
    logic                              rd_start;
    buf_pkg::word_t                    staging_q;
    buf_pkg::word_t                    commit_word;

    // ******************************************************************
    // Address decode
    // ******************************************************************

    assign access = apb_req.psel & apb_req.penable;    // Access phase only
    assign in_window = apb_req.paddr < apb_pkg::WINDOW_BYTES;

    // Byte offset bits 1:0 are dropped
    assign lane = apb_req.paddr[2 +: buf_pkg::LANE_SEL_BITS];
    assign word_addr = apb_req.paddr[2 + buf_pkg::LANE_SEL_BITS +: buf_pkg::ADDR_BITS];

    assign wr_hit = access & apb_req.pwrite & in_window;
    assign rd_start = access & ~apb_req.pwrite & in_window & (state_q == st_idle);

    // ******************************************************************
    // Lane staging
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            staging_q <= '0;
        end else if (wr_hit) begin
            staging_q[lane] <= apb_req.pwdata;
        end
    end

    // Lane 3 comes straight from the bus so the commit needs no extra cycle
    always_comb begin
        commit_word = staging_q;
        commit_word[buf_pkg::LANES-1] = apb_req.pwdata;
    end

    // ******************************************************************
    // Read wait state
    // ******************************************************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (rd_start) begin
                    state_d = st_read_wait;     // Macro data arrives next cycle
                end
            end
            st_read_wait: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // ******************************************************************
    // SRAM request
    // ******************************************************************

    assign ram_req.read_en = rd_start;
    assign ram_req.write_en = wr_hit & (lane == buf_pkg::LANES - 1);
    assign ram_req.addr = word_addr;
    assign ram_req.data = commit_word;

    // ******************************************************************
    // APB response
    // ******************************************************************

    always_comb begin
        apb_rsp = '0;
        if (access) begin
            if (!in_window) begin
                apb_rsp.pready = 1'b1;          // Error completes at once with zero data
                apb_rsp.pslverr = 1'b1;
            end else if (apb_req.pwrite) begin
                apb_rsp.pready = 1'b1;
            end else if (state_q == st_read_wait) begin
                apb_rsp.pready = 1'b1;
                apb_rsp.prdata = ram_rdata[lane];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/buffer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module buffer_top (
    input  logic              clk,
    input  logic              reset,
    input  apb_pkg::apb_req_t apb_req,
    output apb_pkg::apb_rsp_t apb_rsp
);

    buf_pkg::ram_req_t ram_req;
    buf_pkg::word_t    ram_rdata;

    apb_buffer_ctrl apb_buffer_ctrl_inst (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata)
    );

    sram_wrapper sram_wrapper_inst (
        .clk   (clk),
        .reset (reset),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD_NS = 50;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY_NS = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;       // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY_NS);
        reset = 1'b0;                               // Released just after the fourth edge
    end

endmodule

`default_nettype wire

/* bench/buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module buffer_tb;

    localparam int CLK_PERIOD_NS = 100;
    localparam int DRIVE_DELAY_NS = 10;
    localparam int SAMPLE_DELAY_NS = CLK_PERIOD_NS - 2 * DRIVE_DELAY_NS;

    localparam int INIT_WORDS = 32;
    localparam int STAGE_WORDS = 4;
    localparam int MIXED_OPS = 400;
    localparam int ERROR_ROUNDS = 16;
    localparam int NUM_TRANSFERS = INIT_WORDS * 8 + STAGE_WORDS * 12 + MIXED_OPS
                                   + ERROR_ROUNDS * 11;
    localparam int WATCHDOG_NS = NUM_TRANSFERS * 4 * CLK_PERIOD_NS + 20 * CLK_PERIOD_NS;

    logic              clk;
    logic              reset;
    apb_pkg::apb_req_t apb_req;
    apb_pkg::apb_rsp_t apb_rsp;

    integer            seed;

    // Reference model of the memory and the lane staging register
    buf_pkg::word_t    mem_model [buf_pkg::DEPTH];
    bit                valid_model [buf_pkg::DEPTH];
    buf_pkg::word_t    stage_model;
    logic [8:0]        words [$];

    clock_gen clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    buffer_top buffer_top_inst (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // ******************************************************************
    // Failure reporting and compare tasks
    // ******************************************************************

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_idle(input apb_pkg::apb_rsp_t rsp, input string what);
        if (rsp.pready !== 1'b0 || rsp.pslverr !== 1'b0) begin
            report_mismatch($sformatf("%s: pready %b pslverr %b, expected both low",
                                      what, rsp.pready, rsp.pslverr));
        end
    endtask

    task automatic check_rsp(input apb_pkg::apb_rsp_t rsp, input logic [31:0] exp_data,
                             input logic exp_err, input logic with_data, input string what);
        if (rsp.pslverr !== exp_err) begin
            report_mismatch($sformatf("%s: pslverr %b, expected %b", what, rsp.pslverr,
                                      exp_err));
        end
        if (with_data && rsp.prdata !== exp_data) begin
            report_mismatch($sformatf("%s: prdata %h, expected %h", what, rsp.prdata,
                                      exp_data));
        end
    endtask

    task automatic check_word(input buf_pkg::word_t got, input buf_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: word %h, expected %h", what, got, exp));
        end
    endtask

    task automatic expect_access_cycles(input string kind, input logic [15:0] addr,
                                        input int cycles, input int expected);
        if (cycles != expected) begin
            stop_with_error($sformatf("%s at address %h took %0d access cycles, not %0d",
                                      kind, addr, cycles, expected));
        end
    endtask

    // ******************************************************************
    // Random numbers, addresses and the reference model
    // ******************************************************************

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    function automatic int pick(input int n);
        logic [31:0] v;
        v = $random(seed);
        return int'(v[30:0]) % n;
    endfunction

    // Any address at or above the 8 KB window
    function automatic logic [15:0] out_of_window_addr();
        logic [31:0] v;
        v = $random(seed);
        while (v[15:0] < apb_pkg::WINDOW_BYTES) begin
            v = $random(seed);
        end
        return v[15:0];
    endfunction

    function automatic logic [15:0] lane_addr(input logic [8:0] word, input logic [1:0] lane,
                                              input logic [1:0] offset);
        logic [15:0] a;
        a = '0;
        a[12:4] = word;
        a[3:2] = lane;
        a[1:0] = offset;                            // Byte offset must not matter
        return a;
    endfunction

    task automatic model_write(input logic [15:0] addr, input logic [31:0] data);
        logic [8:0] w;
        logic [1:0] l;
        w = addr[12:4];
        l = addr[3:2];
        stage_model[l] = data;
        if (l == 2'd3) begin
            mem_model[w] = stage_model;             // Lane 3 commits the whole staged word
            valid_model[w] = 1'b1;
        end
    endtask

    // ******************************************************************
    // APB transfers
    // ******************************************************************

    task automatic run_transfer(input logic write, input logic [15:0] addr,
                                input logic [31:0] data, output apb_pkg::apb_rsp_t rsp,
                                output int cycles);
        logic done;
        @(posedge clk);
        #(DRIVE_DELAY_NS);
        apb_req.psel = 1'b1;                        // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite = write;
        apb_req.paddr = addr;
        apb_req.pwdata = write ? data : 32'h0;
        @(posedge clk);
        #(DRIVE_DELAY_NS);
        apb_req.penable = 1'b1;
        cycles = 0;
        done = 1'b0;
        rsp = '0;
        while (!done) begin
            cycles++;
            #(SAMPLE_DELAY_NS);                     // Response has settled late in the cycle
            if (apb_rsp.pready) begin
                rsp = apb_rsp;
                done = 1'b1;
            end
            @(posedge clk);
            #(DRIVE_DELAY_NS);
        end
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [31:0] data,
                             output apb_pkg::apb_rsp_t rsp, output int cycles);
        run_transfer(1'b1, addr, data, rsp, cycles);
    endtask

    task automatic apb_read(input logic [15:0] addr, output apb_pkg::apb_rsp_t rsp,
                            output int cycles);
        run_transfer(1'b0, addr, 32'h0, rsp, cycles);
    endtask

    task automatic do_write(input logic [15:0] addr, input logic [31:0] data);
        apb_pkg::apb_rsp_t rsp;
        int                cycles;
        apb_write(addr, data, rsp, cycles);
        model_write(addr, data);
        expect_access_cycles("Write", addr, cycles, 1);
        check_rsp(rsp, 32'h0, 1'b0, 1'b0, $sformatf("write to %h", addr));
    endtask

    task automatic do_read_lane(input logic [15:0] addr);
        apb_pkg::apb_rsp_t rsp;
        int                cycles;
        apb_read(addr, rsp, cycles);
        expect_access_cycles("Read", addr, cycles, 2);
        check_rsp(rsp, mem_model[addr[12:4]][addr[3:2]], 1'b0, 1'b1,
                  $sformatf("read of %h", addr));
    endtask

    task automatic read_word(input logic [8:0] w, output buf_pkg::word_t got);
        apb_pkg::apb_rsp_t rsp;
        int                cycles;
        logic [31:0]       r;
        logic [15:0]       addr;
        for (int ln = 0; ln < buf_pkg::LANES; ln++) begin
            r = next_rand();
            addr = lane_addr(w, ln[1:0], r[1:0]);
            apb_read(addr, rsp, cycles);
            expect_access_cycles("Read", addr, cycles, 2);
            check_rsp(rsp, 32'h0, 1'b0, 1'b0, $sformatf("read of %h", addr));
            got[ln] = rsp.prdata;
        end
    endtask

    task automatic do_bad_access(input logic write, input logic [15:0] addr,
                                 input logic [31:0] data);
        apb_pkg::apb_rsp_t rsp;
        int                cycles;
        run_transfer(write, addr, data, rsp, cycles);
        expect_access_cycles("Out-of-window access", addr, cycles, 1);
        check_rsp(rsp, 32'h0, 1'b1, 1'b1, $sformatf("out-of-window access to %h", addr));
    endtask

    // ******************************************************************
    // Watchdog
    // ******************************************************************

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0d ns, the run did not finish in time", $time);
        $display("Simulation failed");
        $fatal(1);
    end

    // ******************************************************************
    // Test sequence
    // ******************************************************************

    initial begin
        logic [31:0]    r;
        logic [31:0]    d;
        logic [8:0]     w;
        logic [8:0]     w2;
        buf_pkg::word_t got;

        apb_req = '0;
        seed = 87;
        stage_model = '0;
        for (int i = 0; i < buf_pkg::DEPTH; i++) begin
            valid_model[i] = 1'b0;
        end

        // Idle response through and after reset
        repeat (8) begin
            @(posedge clk);
            #(CLK_PERIOD_NS - DRIVE_DELAY_NS);
            check_idle(apb_rsp, "idle response around reset");
        end

        // Full-word round trip
        for (int i = 0; i < INIT_WORDS; i++) begin
            do begin
                r = next_rand();
                w = r[8:0];
            end while (valid_model[w]);
            for (int ln = 0; ln < buf_pkg::LANES; ln++) begin
                r = next_rand();
                d = next_rand();
                do_write(lane_addr(w, ln[1:0], r[1:0]), d);
            end
            words.push_back(w);
        end
        foreach (words[i]) begin
            read_word(words[i], got);
            check_word(got, mem_model[words[i]], $sformatf("round trip of word %0d", words[i]));
        end

        // Staged lanes stay out of memory until lane 3 is written
        for (int i = 0; i < STAGE_WORDS; i++) begin
            w = words[pick(words.size())];
            for (int ln = 0; ln < buf_pkg::LANES - 1; ln++) begin
                r = next_rand();
                d = next_rand();
                do_write(lane_addr(w, ln[1:0], r[1:0]), d);
            end
            read_word(w, got);
            check_word(got, mem_model[w], $sformatf("word %0d before commit", w));
            r = next_rand();
            d = next_rand();
            do_write(lane_addr(w, 2'd3, r[1:0]), d);
            read_word(w, got);
            check_word(got, mem_model[w], $sformatf("word %0d after commit", w));
        end

        // Random mixed traffic over the initialized words
        repeat (MIXED_OPS) begin
            w = words[pick(words.size())];
            r = next_rand();
            if (r[2] || !valid_model[w]) begin
                d = next_rand();
                do_write(lane_addr(w, r[1:0], r[4:3]), d);
            end else begin
                do_read_lane(lane_addr(w, r[1:0], r[4:3]));
            end
        end

        // Out-of-window accesses leave memory and staging alone
        for (int i = 0; i < ERROR_ROUNDS; i++) begin
            w = words[pick(words.size())];
            for (int ln = 0; ln < buf_pkg::LANES - 1; ln++) begin
                r = next_rand();
                d = next_rand();
                do_write(lane_addr(w, ln[1:0], r[1:0]), d);
            end
            d = next_rand();
            do_bad_access(1'b1, out_of_window_addr(), d);
            do_bad_access(1'b0, out_of_window_addr(), 32'h0);
            w2 = words[pick(words.size())];
            r = next_rand();
            do_read_lane(lane_addr(w2, r[1:0], r[3:2]));
            d = next_rand();
            do_write(lane_addr(w, 2'd3, r[5:4]), d);
            read_word(w, got);
            check_word(got, mem_model[w], $sformatf("word %0d committed after errors", w));
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/buf_pkg.sv
hw/apb_pkg.sv
hw/delay_line.sv
hw/sram_sp_model.sv
hw/sram_wrapper.sv
hw/apb_buffer_ctrl.sv
hw/buffer_top.sv
bench/clock_gen.sv
bench/buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the buffer testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary -f vlog.f --top-module buffer_tb -o buffer_sim

# The simulator status is not used here, the log decides the result
./obj_dir/buffer_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Testbench reported a failure, see sim.log"
    exit 1
fi

echo "No failure found in sim.log"
exit 0
